//--- flist.f
+incdir+source
source/mdu_pkg.sv
source/mul_unsigned.sv
source/mul_sign_wrap.sv
source/div_unsigned.sv
source/div_sign_wrap.sv
source/mdu_top.sv
tb/mdu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MDU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mdu_tb -f flist.f -o mdu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/mdu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- source/div_sign_wrap.sv
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module div_sign_wrap (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  mdu_pkg::mdu_op_e      op,
  input  logic [`MDU_XLEN-1:0]  a,
  input  logic [`MDU_XLEN-1:0]  b,
  output logic [`MDU_XLEN-1:0]  result,
  output logic                  done
);

  logic                  is_signed;
  logic                  b_zero;
  logic [`MDU_XLEN-1:0]  a_mag;
  logic [`MDU_XLEN-1:0]  b_mag;
  logic [`MDU_XLEN-1:0]  core_quo;
  logic [`MDU_XLEN-1:0]  core_rem;
  logic [`MDU_XLEN-1:0]  quo_fix;
  logic [`MDU_XLEN-1:0]  rem_fix;
  mdu_pkg::mdu_op_e      op_q;
  logic                  q_neg_q;
  logic                  r_neg_q;

  //////////////////////////////
  // Operand magnitudes
  //////////////////////////////

  assign is_signed = (op == mdu_pkg::OP_DIV) || (op == mdu_pkg::OP_REM);
  assign b_zero    = (b == '0);

  assign a_mag = (is_signed && a[`MDU_XLEN-1]) ? (~a + 1'b1) : a;
  assign b_mag = (is_signed && b[`MDU_XLEN-1]) ? (~b + 1'b1) : b;

  // Quotient sign dropped on divide by zero
  // so all ones comes out unchanged
  always_ff @(posedge clk) begin
    if (start) begin
      op_q    <= op;
      q_neg_q <= is_signed & (a[`MDU_XLEN-1] ^ b[`MDU_XLEN-1]) & ~b_zero;
      r_neg_q <= is_signed & a[`MDU_XLEN-1];
    end
  end

  div_unsigned u_div (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .dividend  (a_mag),
    .divisor   (b_mag),
    .quotient  (core_quo),
    .remainder (core_rem),
    .done      (done)
  );

  //////////////////////////////
  // Sign fix and select
  //////////////////////////////

  // Truncation toward zero
  assign quo_fix = q_neg_q ? (~core_quo + 1'b1) : core_quo;
  // Remainder follows the dividend sign
  // Divide by zero restores the original dividend here
  assign rem_fix = r_neg_q ? (~core_rem + 1'b1) : core_rem;

  // Overflow case needs no special path:
  // magnitude 2^31 over 1, signs cancel, remainder zero
  always_comb begin
    case (op_q)
      mdu_pkg::OP_DIV, mdu_pkg::OP_DIVU: result = quo_fix;
      default:                           result = rem_fix;
    endcase
  end

endmodule

//--- source/div_unsigned.sv
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module div_unsigned (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic [`MDU_XLEN-1:0]  dividend,
  input  logic [`MDU_XLEN-1:0]  divisor,
  output logic [`MDU_XLEN-1:0]  quotient,
  output logic [`MDU_XLEN-1:0]  remainder,
  output logic                  done
);

  localparam int CNT_W = $clog2(`MDU_ITER);

  mdu_pkg::core_state_e      state;
  logic [CNT_W-1:0]          cnt;
  logic                      last_iter;
  logic [`MDU_XLEN-1:0]      rem_q;
  logic [`MDU_XLEN-1:0]      quo_q;
  logic [`MDU_XLEN-1:0]      dvsr_q;
  logic [`MDU_XLEN:0]        shifted;
  logic [`MDU_XLEN+1:0]      diff;
  logic                      fits;

  assign last_iter = (cnt == CNT_W'(`MDU_ITER - 1));

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mdu_pkg::ST_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        mdu_pkg::ST_IDLE: begin
          if (start) begin
            state <= mdu_pkg::ST_RUN;
            cnt   <= '0;
          end
        end
        mdu_pkg::ST_RUN: begin
          cnt <= cnt + 1'b1;
          if (last_iter) begin
            state <= mdu_pkg::ST_DONE;
          end
        end
        mdu_pkg::ST_DONE: begin
          done  <= 1'b1;
          state <= mdu_pkg::ST_IDLE;
        end
        default: state <= mdu_pkg::ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Restoring step
  //////////////////////////////

  // Next dividend bit enters the partial remainder
  assign shifted = {rem_q, quo_q[`MDU_XLEN-1]};
  // Extra top bit flags a negative trial difference
  assign diff    = {1'b0, shifted} - {2'b00, dvsr_q};
  assign fits    = ~diff[`MDU_XLEN+1];

  // quo_q doubles as dividend shift register
  always_ff @(posedge clk) begin
    if (state == mdu_pkg::ST_IDLE && start) begin
      rem_q  <= '0;
      quo_q  <= dividend;
      dvsr_q <= divisor;
    end else if (state == mdu_pkg::ST_RUN) begin
      // Zero divisor always fits, giving all-ones quotient
      rem_q <= fits ? diff[`MDU_XLEN-1:0] : shifted[`MDU_XLEN-1:0];
      quo_q <= {quo_q[`MDU_XLEN-2:0], fits};
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

//--- source/mdu_cfg.svh
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// Operand width of the RV32 datapath
`define MDU_XLEN 32

// One bit per cycle in both iterative cores
`define MDU_ITER `MDU_XLEN

`endif

//--- source/mdu_pkg.sv
package mdu_pkg;

  //////////////////////////////
  // Operation codes
  //////////////////////////////

  // Values follow funct3 of the M extension
  // Bit 2 splits multiply from divide
  typedef enum logic [2:0] {
    OP_MUL    = 3'b000,
    OP_MULH   = 3'b001,
    OP_MULHSU = 3'b010,
    OP_MULHU  = 3'b011,
    OP_DIV    = 3'b100,
    OP_DIVU   = 3'b101,
    OP_REM    = 3'b110,
    OP_REMU   = 3'b111
  } mdu_op_e;

  // Shared FSM of the iterative cores
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } core_state_e;

endpackage

//--- source/mdu_top.sv
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mdu_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  mdu_pkg::mdu_op_e      mdu_op,
  input  logic [`MDU_XLEN-1:0]  a,
  input  logic [`MDU_XLEN-1:0]  b,
  output logic [`MDU_XLEN-1:0]  result,
  output logic                  done,
  output logic                  busy
);

  logic                     accept;
  logic                     mul_start;
  logic                     div_start;
  logic                     is_div_q;
  logic                     hi_q;
  logic [2*`MDU_XLEN-1:0]   mul_res;
  logic [`MDU_XLEN-1:0]     div_res;
  logic                     mul_done;
  logic                     div_done;
  logic                     unit_done;

  //////////////////////////////
  // Start routing
  //////////////////////////////

  // Start ignored while an op is in flight
  assign accept    = start & ~busy;
  // Bit 2 of funct3 picks the divider
  assign mul_start = accept & ~mdu_op[2];
  assign div_start = accept & mdu_op[2];

  mul_sign_wrap u_mul_wrap (
    .clk    (clk),
    .rst    (rst),
    .start  (mul_start),
    .op     (mdu_op),
    .a      (a),
    .b      (b),
    .result (mul_res),
    .done   (mul_done)
  );

  div_sign_wrap u_div_wrap (
    .clk    (clk),
    .rst    (rst),
    .start  (div_start),
    .op     (mdu_op),
    .a      (a),
    .b      (b),
    .result (div_res),
    .done   (div_done)
  );

  // Only one unit active at a time
  assign unit_done = mul_done | div_done;

  //////////////////////////////
  // Busy and result registers
  //////////////////////////////

  // Class and half select kept for the whole op
  always_ff @(posedge clk) begin
    if (accept) begin
      is_div_q <= mdu_op[2];
      hi_q     <= (mdu_op != mdu_pkg::OP_MUL);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      // Busy drops after the cycle with done high
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      done <= unit_done;
      // Last result held between ops
      if (unit_done) begin
        if (is_div_q) begin
          result <= div_res;
        end else if (hi_q) begin
          result <= mul_res[2*`MDU_XLEN-1:`MDU_XLEN];
        end else begin
          result <= mul_res[`MDU_XLEN-1:0];
        end
      end
    end
  end

endmodule

//--- source/mul_sign_wrap.sv
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mul_sign_wrap (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  mdu_pkg::mdu_op_e         op,
  input  logic [`MDU_XLEN-1:0]     a,
  input  logic [`MDU_XLEN-1:0]     b,
  output logic [2*`MDU_XLEN-1:0]   result,
  output logic                     done
);

  logic                     a_signed;
  logic                     b_signed;
  logic [`MDU_XLEN-1:0]     a_mag;
  logic [`MDU_XLEN-1:0]     b_mag;
  logic [2*`MDU_XLEN-1:0]   core_prod;
  mdu_pkg::mdu_op_e         op_q;
  logic                     a_sgn_q;
  logic                     b_sgn_q;
  logic                     neg_result;

  //////////////////////////////
  // Operand magnitudes
  //////////////////////////////

  // Which operands count as signed for this op
  always_comb begin
    a_signed = 1'b0;
    b_signed = 1'b0;
    case (op)
      mdu_pkg::OP_MUL, mdu_pkg::OP_MULH: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      mdu_pkg::OP_MULHSU: a_signed = 1'b1;
      default: ;
    endcase
  end

  // Most negative value maps onto itself, still correct unsigned
  assign a_mag = (a_signed && a[`MDU_XLEN-1]) ? (~a + 1'b1) : a;
  assign b_mag = (b_signed && b[`MDU_XLEN-1]) ? (~b + 1'b1) : b;

  // Sign info captured with the operands
  always_ff @(posedge clk) begin
    if (start) begin
      op_q    <= op;
      a_sgn_q <= a[`MDU_XLEN-1];
      b_sgn_q <= b[`MDU_XLEN-1];
    end
  end

  mul_unsigned u_mul (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .a       (a_mag),
    .b       (b_mag),
    .product (core_prod),
    .done    (done)
  );

  //////////////////////////////
  // Result sign correction
  //////////////////////////////

  always_comb begin
    case (op_q)
      mdu_pkg::OP_MUL, mdu_pkg::OP_MULH: neg_result = a_sgn_q ^ b_sgn_q;
      mdu_pkg::OP_MULHSU:                neg_result = a_sgn_q;
      default:                           neg_result = 1'b0;
    endcase
  end

  // Full 64-bit two's complement
  assign result = neg_result ? (~core_prod + 1'b1) : core_prod;

endmodule

//--- source/mul_unsigned.sv
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mul_unsigned (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  logic [`MDU_XLEN-1:0]     a,
  input  logic [`MDU_XLEN-1:0]     b,
  output logic [2*`MDU_XLEN-1:0]   product,
  output logic                     done
);

  localparam int CNT_W = $clog2(`MDU_ITER);

  mdu_pkg::core_state_e     state;
  logic [CNT_W-1:0]         cnt;
  logic                     last_iter;
  logic [2*`MDU_XLEN-1:0]   acc;
  logic [2*`MDU_XLEN-1:0]   mcand;
  logic [`MDU_XLEN-1:0]     mplier;

  // Final iteration reached
  assign last_iter = (cnt == CNT_W'(`MDU_ITER - 1));

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mdu_pkg::ST_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      // Done is a one-cycle strobe
      done <= 1'b0;
      case (state)
        mdu_pkg::ST_IDLE: begin
          if (start) begin
            state <= mdu_pkg::ST_RUN;
            cnt   <= '0;
          end
        end
        mdu_pkg::ST_RUN: begin
          cnt <= cnt + 1'b1;
          if (last_iter) begin
            state <= mdu_pkg::ST_DONE;
          end
        end
        mdu_pkg::ST_DONE: begin
          // Accumulator already complete here
          done  <= 1'b1;
          state <= mdu_pkg::ST_IDLE;
        end
        default: state <= mdu_pkg::ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Shift-add datapath
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (state == mdu_pkg::ST_IDLE && start) begin
      acc    <= '0;
      mcand  <= {{`MDU_XLEN{1'b0}}, a};
      mplier <= b;
    end else if (state == mdu_pkg::ST_RUN) begin
      // Add shifted multiplicand for each set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Held until the next start
  assign product = acc;

endmodule

//--- tb/mdu_tb.sv
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mdu_tb;

  localparam int MAX_VEC    = 64;
  localparam int WAIT_LIMIT = 100;
  // Core iterations, one core done cycle, one top register
  localparam int LATENCY    = `MDU_ITER + 2;
  localparam int HALF_WAY   = LATENCY / 2;
  localparam int QUIET_CYC  = 40;

  logic                  clk;
  logic                  rst;
  logic                  start;
  mdu_pkg::mdu_op_e      mdu_op;
  logic [`MDU_XLEN-1:0]  a;
  logic [`MDU_XLEN-1:0]  b;
  logic [`MDU_XLEN-1:0]  result;
  logic                  done;
  logic                  busy;

  // Vector table
  string                 name_mem [MAX_VEC];
  logic [2:0]            op_mem   [MAX_VEC];
  logic [`MDU_XLEN-1:0]  a_mem    [MAX_VEC];
  logic [`MDU_XLEN-1:0]  b_mem    [MAX_VEC];
  logic [`MDU_XLEN-1:0]  exp_mem  [MAX_VEC];
  int                    nvec;

  int                    n_checks;
  int                    n_mismatch;
  int                    n_fail;
  bit                    aborted;
  integer                seed;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  mdu_top dut0 (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .mdu_op (mdu_op),
    .a      (a),
    .b      (b),
    .result (result),
    .done   (done),
    .busy   (busy)
  );

  //////////////////////////////
  // Checking helpers
  //////////////////////////////

  task automatic check_val(input string tag, input string field,
                           input logic [`MDU_XLEN-1:0] expected,
                           input logic [`MDU_XLEN-1:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_mismatch++;
      $display("MISMATCH %s %s: expected %h, actual %h", tag, field, expected, actual);
    end
  endtask

  // Outputs quiet in and just after reset
  task automatic check_idle_outputs(input string tag);
    check_val(tag, "done", 32'd0, 32'(done));
    check_val(tag, "busy", 32'd0, 32'(busy));
    check_val(tag, "result", 32'd0, result);
  endtask

  //////////////////////////////
  // Vector file
  //////////////////////////////

  task automatic load_vectors();
    int                    fd;
    int                    code;
    bit                    reading;
    logic [8*24-1:0]       tok;
    logic [8*128-1:0]      line;
    logic [`MDU_XLEN-1:0]  v_op;
    logic [`MDU_XLEN-1:0]  v_a;
    logic [`MDU_XLEN-1:0]  v_b;
    logic [`MDU_XLEN-1:0]  v_exp;
    nvec = 0;
    fd = $fopen("tb/mdu_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/mdu_vectors.txt");
      n_fail++;
      aborted = 1'b1;
      return;
    end
    reading = 1'b1;
    while (reading) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        reading = 1'b0;
      end else if (tok[7:0] == "#" && tok[8*24-1:8] == '0) begin
        // Comment line, rest dropped
        code = $fgets(line, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h", v_op, v_a, v_b, v_exp);
        if (code != 4 || v_op > 32'd7 || nvec >= MAX_VEC) begin
          $display("Vector entry %0d is malformed or does not fit the table", nvec);
          n_fail++;
          aborted = 1'b1;
          reading = 1'b0;
        end else begin
          name_mem[nvec] = $sformatf("%0s", tok);
          op_mem[nvec]   = v_op[2:0];
          a_mem[nvec]    = v_a;
          b_mem[nvec]    = v_b;
          exp_mem[nvec]  = v_exp;
          nvec++;
        end
      end
    end
    $fclose(fd);
    if (nvec == 0 && !aborted) begin
      $display("The vector file holds no operations");
      n_fail++;
      aborted = 1'b1;
    end
  endtask

  //////////////////////////////
  // One operation
  //////////////////////////////

  task automatic run_op(input string tag, input logic [2:0] op,
                        input logic [`MDU_XLEN-1:0] op_a,
                        input logic [`MDU_XLEN-1:0] op_b,
                        input logic [`MDU_XLEN-1:0] expected, input bit intrude);
    int lat;
    int i;
    bit seen;
    @(posedge clk);
    start  <= 1'b1;
    mdu_op <= mdu_pkg::mdu_op_e'(op);
    a      <= op_a;
    b      <= op_b;
    // DUT takes start on this edge
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    // Busy rises in the cycle after the accepting edge
    check_val(tag, "busy", 32'd1, 32'(busy));
    lat  = 0;
    seen = 1'b0;
    while (!seen && lat < WAIT_LIMIT) begin
      @(posedge clk);
      lat++;
      if (intrude && lat == HALF_WAY) begin
        // Second start mid-run, divide class, new operands
        start  <= 1'b1;
        mdu_op <= mdu_pkg::OP_DIV;
        a      <= ~op_a;
        b      <= op_b + 32'd1;
      end else if (intrude && lat == HALF_WAY + 1) begin
        start <= 1'b0;
      end
      @(negedge clk);
      seen = done;
      // Busy up through the done cycle
      check_val(tag, "busy", 32'd1, 32'(busy));
    end
    if (!seen) begin
      $display("Test %s never finished: no done within %0d cycles", tag, WAIT_LIMIT);
      n_fail++;
      aborted = 1'b1;
    end else begin
      check_val(tag, "latency", LATENCY, lat);
      check_val(tag, "result", expected, result);
      @(negedge clk);
      // Single-cycle strobe, busy released, result kept
      check_val(tag, "done width", 32'd0, 32'(done));
      check_val(tag, "busy after done", 32'd0, 32'(busy));
      check_val(tag, "result hold", expected, result);
      if (intrude) begin
        for (i = 0; i < QUIET_CYC; i++) begin
          @(negedge clk);
          check_val(tag, "extra done", 32'd0, 32'(done));
        end
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int idle;
    int k;
    seed       = 32'hdec0_d132;
    n_checks   = 0;
    n_mismatch = 0;
    n_fail     = 0;
    aborted    = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    mdu_op     = mdu_pkg::OP_MUL;
    a          = '0;
    b          = '0;
    load_vectors();
    // Reset spans 16 rising edges
    repeat (15) begin
      @(negedge clk);
      check_idle_outputs("in_reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle_outputs("after_reset");
    end
    for (k = 0; k < nvec && !aborted; k++) begin
      run_op(name_mem[k], op_mem[k], a_mem[k], b_mem[k], exp_mem[k], 1'b0);
      idle = $unsigned($random(seed)) % 6;
      repeat (idle) @(posedge clk);
    end
    // First vector again with an ignored start halfway
    if (!aborted) begin
      run_op("busy_ignore", op_mem[0], a_mem[0], b_mem[0], exp_mem[0], 1'b1);
    end
    $display("Checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_fail);
    if (n_mismatch == 0 && n_fail == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- tb/mdu_vectors.txt
# name opcode a b expected, all hex except the name
# opcode is funct3: 0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU
mul_small        0 00000007 00000006 0000002a
mul_negpos       0 fffffffd 00000005 fffffff1
mul_zero         0 12345678 00000000 00000000
mul_ones         0 ffffffff ffffffff 00000001
mul_minneg       0 80000000 00000002 00000000
mul_wrap         0 00010001 00010001 00020001
mulh_negpos      1 fffffffd 00000005 ffffffff
mulh_ones        1 ffffffff ffffffff 00000000
mulh_minneg      1 80000000 80000000 40000000
mulh_min_neg1    1 80000000 ffffffff 00000000
mulh_pos         1 7fffffff 7fffffff 3fffffff
mulhsu_neg1_max  2 ffffffff ffffffff ffffffff
mulhsu_minneg    2 80000000 ffffffff 80000000
mulhsu_pos       2 7fffffff ffffffff 7ffffffe
mulhsu_zero      2 80000000 00000000 00000000
mulhu_ones       3 ffffffff ffffffff fffffffe
mulhu_wrap       3 00010001 00010001 00000001
mulhu_minneg     3 80000000 80000000 40000000
div_pos          4 00000014 00000006 00000003
div_negpos       4 ffffffec 00000006 fffffffd
div_posneg       4 00000014 fffffffa fffffffd
div_negneg       4 ffffffec fffffffa 00000003
div_by_zero      4 00000123 00000000 ffffffff
div_ovf          4 80000000 ffffffff 80000000
divu_big         5 ffffffec 00000006 2aaaaaa7
divu_by_zero     5 00000123 00000000 ffffffff
rem_negpos       6 ffffffec 00000006 fffffffe
rem_posneg       6 00000014 fffffffa 00000002
rem_negneg       6 ffffffec fffffffa fffffffe
rem_by_zero      6 fffffff0 00000000 fffffff0
rem_ovf          6 80000000 ffffffff 00000000
remu_big         7 ffffffec 00000006 00000002
remu_by_zero     7 00000123 00000000 00000123
